// ==== Bender.yml ====
package:
  name: shop_monitor

sources:
  - shop_mon_pkg.sv
  - shop_req_if.sv
  - shop_resp_if.sv
  - strobe_rules.sv
  - sequence_tracker.sv
  - response_rules.sv
  - violation_report.sv
  - shop_monitor.sv
  - target: test
    files:
      - tb_shop_monitor.sv

// ==== flist.f ====
shop_mon_pkg.sv
shop_req_if.sv
shop_resp_if.sv
strobe_rules.sv
sequence_tracker.sv
response_rules.sv
violation_report.sv
shop_monitor.sv
tb_shop_monitor.sv

// ==== response_rules.sv ====
// Response field consistency
// complete needs a zero err_msg, not complete needs a zero out_info

`timescale 1ns/1ns

module response_rules (
	shop_resp_if.mon            resp,
	output shop_mon_pkg::viol_e viol
);

	logic err_bad;
	logic info_bad;

	// Only meaningful while out_valid is high
	assign err_bad  = resp.complete && (resp.err_msg != '0);
	assign info_bad = !resp.complete && (resp.out_info != '0);

	always_comb begin
		viol = shop_mon_pkg::viol_none;
		if (resp.out_valid && (err_bad || info_bad))
			viol = shop_mon_pkg::viol_resp_field;
	end

endmodule

// ==== sequence_tracker.sv ====
// Per-action input order tracking
// Phase FSM with one expected request strobe per phase,
// stray strobe and early response detection

`timescale 1ns/1ns

module sequence_tracker (
	input  logic                clk,
	input  logic                rst_n,
	shop_req_if.mon             req,
	shop_resp_if.mon            resp,
	output shop_mon_pkg::viol_e viol
);

	// Strobe vector order is id, act, item, num, amnt
	localparam logic [4:0] S_ID   = 5'b10000;
	localparam logic [4:0] S_ACT  = 5'b01000;
	localparam logic [4:0] S_ITEM = 5'b00100;
	localparam logic [4:0] S_NUM  = 5'b00010;
	localparam logic [4:0] S_AMNT = 5'b00001;

	shop_mon_pkg::phase_e phase;
	shop_mon_pkg::phase_e phase_nxt;
	logic [4:0]           req_now;
	logic [4:0]           expect_mask;
	logic                 stray;
	logic                 early;

	// First phase after the action strobe
	function automatic shop_mon_pkg::phase_e act_target(input shop_mon_pkg::action_e a);
		shop_mon_pkg::phase_e p;
		case (a)
			shop_mon_pkg::act_deposit: p = shop_mon_pkg::ph_amount;
			shop_mon_pkg::act_check:   p = shop_mon_pkg::ph_check_open;
			default:                   p = shop_mon_pkg::ph_item;
		endcase
		return p;
	endfunction

	assign req_now = {req.id_valid, req.act_valid, req.item_valid,
		req.num_valid, req.amnt_valid};

	// ##################################################
	// Expected strobe and next phase
	// ##################################################
	always_comb begin
		expect_mask = '0;
		phase_nxt   = phase;
		case (phase)
			shop_mon_pkg::ph_idle: begin
				expect_mask = S_ID | S_ACT;
				if (req.act_valid)
					phase_nxt = act_target(req.act);
				else if (req.id_valid)
					phase_nxt = shop_mon_pkg::ph_user;
			end
			shop_mon_pkg::ph_user: begin
				expect_mask = S_ACT;
				if (req.act_valid)
					phase_nxt = act_target(req.act);
			end
			shop_mon_pkg::ph_item: begin
				expect_mask = S_ITEM;
				if (req.item_valid)
					phase_nxt = shop_mon_pkg::ph_num;
			end
			shop_mon_pkg::ph_num: begin
				expect_mask = S_NUM;
				if (req.num_valid)
					phase_nxt = shop_mon_pkg::ph_seller;
			end
			shop_mon_pkg::ph_amount: begin
				expect_mask = S_AMNT;
				if (req.amnt_valid)
					phase_nxt = shop_mon_pkg::ph_done;
			end
			shop_mon_pkg::ph_seller, shop_mon_pkg::ph_check_open: begin
				expect_mask = S_ID;
				if (req.id_valid)
					phase_nxt = shop_mon_pkg::ph_done;
			end
			default: expect_mask = '0;
		endcase
		// Response always closes the sequence
		if (resp.out_valid)
			phase_nxt = shop_mon_pkg::ph_idle;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			phase <= shop_mon_pkg::ph_idle;
		else
			phase <= phase_nxt;
	end

	assign stray = |(req_now & ~expect_mask);
	assign early = resp.out_valid && (phase != shop_mon_pkg::ph_check_open)
		&& (phase != shop_mon_pkg::ph_done);

	always_comb begin
		viol = shop_mon_pkg::viol_none;
		if (stray)
			viol = shop_mon_pkg::viol_order;
		else if (early)
			viol = shop_mon_pkg::viol_early_resp;
	end

	a_phase_known : assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown(phase));

endmodule

// ==== shop_mon_pkg.sv ====
// Shared types and widths for the shop protocol monitor
// Action codes, violation codes and tracker phases
// Field widths and rule mask size

package shop_mon_pkg;

	// Request action code
	typedef enum logic [1:0] {
		act_buy     = 2'd0,
		act_check   = 2'd1,
		act_deposit = 2'd2,
		act_return  = 2'd3
	} action_e;

	// Reported violation classes, mask bit k enables value k+1
	typedef enum logic [2:0] {
		viol_none         = 3'd0,
		viol_multi_strobe = 3'd1,
		viol_held_strobe  = 3'd2,
		viol_order        = 3'd3,
		viol_early_resp   = 3'd4,
		viol_resp_field   = 3'd5
	} viol_e;

	// Sequence tracker state
	typedef enum logic [2:0] {
		ph_idle,
		ph_user,
		ph_item,
		ph_num,
		ph_seller,
		ph_amount,
		ph_check_open,
		ph_done
	} phase_e;

	localparam int ERR_W  = 4;
	localparam int INFO_W = 32;
	localparam int CNT_W  = 16;
	localparam int RULE_N = 5;

endpackage

// ==== shop_monitor.sv ====
// Shop controller protocol monitor, top level
// Bundles plain ports into request and response interfaces
// and connects the three checkers to the report stage

`timescale 1ns/1ns

module shop_monitor (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              id_valid,
	input  logic                              act_valid,
	input  logic                              item_valid,
	input  logic                              num_valid,
	input  logic                              amnt_valid,
	input  shop_mon_pkg::action_e             act,
	input  logic                              out_valid,
	input  logic                              complete,
	input  logic [shop_mon_pkg::ERR_W-1:0]    err_msg,
	input  logic [shop_mon_pkg::INFO_W-1:0]   out_info,
	input  logic                              cfg_we,
	input  logic [shop_mon_pkg::RULE_N-1:0]   cfg_mask,
	input  logic                              cfg_clear,
	output logic                              viol_valid,
	output shop_mon_pkg::viol_e               viol_code,
	output logic [shop_mon_pkg::CNT_W-1:0]    viol_count,
	output shop_mon_pkg::viol_e               first_code
);

	shop_mon_pkg::viol_e viol_strobe;
	shop_mon_pkg::viol_e viol_order;
	shop_mon_pkg::viol_e viol_resp;

	shop_req_if  req_bus ();
	shop_resp_if resp_bus ();

	// Port bundling
	assign req_bus.id_valid   = id_valid;
	assign req_bus.act_valid  = act_valid;
	assign req_bus.item_valid = item_valid;
	assign req_bus.num_valid  = num_valid;
	assign req_bus.amnt_valid = amnt_valid;
	assign req_bus.act        = act;
	assign resp_bus.out_valid = out_valid;
	assign resp_bus.complete  = complete;
	assign resp_bus.err_msg   = err_msg;
	assign resp_bus.out_info  = out_info;

	strobe_rules strobe_rules_i (
		.clk  (clk),
		.rst_n(rst_n),
		.req  (req_bus.mon),
		.resp (resp_bus.mon),
		.viol (viol_strobe)
	);

	sequence_tracker sequence_tracker_i (
		.clk  (clk),
		.rst_n(rst_n),
		.req  (req_bus.mon),
		.resp (resp_bus.mon),
		.viol (viol_order)
	);

	response_rules response_rules_i (
		.resp(resp_bus.mon),
		.viol(viol_resp)
	);

	violation_report violation_report_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.viol_strobe(viol_strobe),
		.viol_order (viol_order),
		.viol_resp  (viol_resp),
		.cfg_we     (cfg_we),
		.cfg_mask   (cfg_mask),
		.cfg_clear  (cfg_clear),
		.viol_valid (viol_valid),
		.viol_code  (viol_code),
		.viol_count (viol_count),
		.first_code (first_code)
	);

endmodule

// ==== shop_req_if.sv ====
// Request side bundle of the shop controller
// Five input strobes plus the action code

`timescale 1ns/1ns

interface shop_req_if;

	logic                  id_valid;
	logic                  act_valid;
	logic                  item_valid;
	logic                  num_valid;
	logic                  amnt_valid;
	shop_mon_pkg::action_e act;

	// Driven from the monitor top
	modport src (
		output id_valid, act_valid, item_valid, num_valid, amnt_valid, act
	);

	// Checkers only observe
	modport mon (
		input id_valid, act_valid, item_valid, num_valid, amnt_valid, act
	);

endinterface

// ==== shop_resp_if.sv ====
// Response side bundle of the shop controller
// One-cycle out_valid with status and payload fields

`timescale 1ns/1ns

interface shop_resp_if;

	logic                            out_valid;
	logic                            complete;
	logic [shop_mon_pkg::ERR_W-1:0]  err_msg;
	logic [shop_mon_pkg::INFO_W-1:0] out_info;

	// Driven from the monitor top
	modport src (
		output out_valid, complete, err_msg, out_info
	);

	// Checkers only observe
	modport mon (
		input out_valid, complete, err_msg, out_info
	);

endinterface

// ==== strobe_rules.sv ====
// Strobe shape checks
// One request strobe per cycle at most, and every strobe
// (request or response) lasts a single cycle

`timescale 1ns/1ns

module strobe_rules (
	input  logic                clk,
	input  logic                rst_n,
	shop_req_if.mon             req,
	shop_resp_if.mon            resp,
	output shop_mon_pkg::viol_e viol
);

	logic [4:0] req_now;
	logic [4:0] req_prev;
	logic       resp_prev;
	logic       multi_hit;
	logic       held_hit;

	assign req_now = {req.id_valid, req.act_valid, req.item_valid,
		req.num_valid, req.amnt_valid};

	// Last cycle's strobes
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			req_prev  <= '0;
			resp_prev <= 1'b0;
		end else begin
			req_prev  <= req_now;
			resp_prev <= resp.out_valid;
		end
	end

	// More than one bit set clears to nonzero after dropping the lowest bit
	assign multi_hit = |(req_now & (req_now - 5'd1));
	assign held_hit  = (|(req_now & req_prev)) | (resp.out_valid & resp_prev);

	always_comb begin
		viol = shop_mon_pkg::viol_none;
		if (multi_hit)
			viol = shop_mon_pkg::viol_multi_strobe;
		else if (held_hit)
			viol = shop_mon_pkg::viol_held_strobe;
	end

	a_viol_range : assert property (@(posedge clk) disable iff (!rst_n)
		viol inside {shop_mon_pkg::viol_none, shop_mon_pkg::viol_multi_strobe,
			shop_mon_pkg::viol_held_strobe});

endmodule

// ==== tb_shop_monitor.sv ====
// Testbench for the shop protocol monitor
// Reference model of the strobe, order, response and report rules
// Directed and random stimulus, checking by assertions

`timescale 1ns/1ns

module tb_shop_monitor;

	// Strobe vector order is id, act, item, num, amnt
	localparam logic [4:0] S_ID   = 5'b10000;
	localparam logic [4:0] S_ACT  = 5'b01000;
	localparam logic [4:0] S_ITEM = 5'b00100;
	localparam logic [4:0] S_NUM  = 5'b00010;
	localparam logic [4:0] S_AMNT = 5'b00001;

	logic                              clk = 1'b0;
	logic                              rst_n;
	logic                              id_valid;
	logic                              act_valid;
	logic                              item_valid;
	logic                              num_valid;
	logic                              amnt_valid;
	shop_mon_pkg::action_e             act;
	logic                              out_valid;
	logic                              complete;
	logic [shop_mon_pkg::ERR_W-1:0]    err_msg;
	logic [shop_mon_pkg::INFO_W-1:0]   out_info;
	logic                              cfg_we;
	logic [shop_mon_pkg::RULE_N-1:0]   cfg_mask;
	logic                              cfg_clear;
	logic                              viol_valid;
	shop_mon_pkg::viol_e               viol_code;
	logic [shop_mon_pkg::CNT_W-1:0]    viol_count;
	shop_mon_pkg::viol_e               first_code;

	integer seed = 32'hcfb6_b2b5;
	int     errors = 0;
	int     tests = 0;
	int     err_mark = 0;

	// Reference model state
	logic [4:0]                      m_prev_req;
	logic                            m_prev_out;
	shop_mon_pkg::phase_e            m_phase;
	logic [4:0]                      m_mask;
	logic                            exp_valid;
	shop_mon_pkg::viol_e             exp_code;
	logic [shop_mon_pkg::CNT_W-1:0]  exp_count;
	shop_mon_pkg::viol_e             exp_first;
	logic [5:0]                      seen = '0;
	logic [4:0]                      cur_req;
	shop_mon_pkg::viol_e             c_strobe;
	shop_mon_pkg::viol_e             c_order;
	shop_mon_pkg::viol_e             c_resp;
	shop_mon_pkg::viol_e             m_pick;

	shop_monitor shop_monitor_i (.*);

	always #10 clk = ~clk;

	// ##################################################
	// Reference model
	// ##################################################
	function automatic shop_mon_pkg::viol_e strobe_model(input logic [4:0] r,
		input logic [4:0] pr, input logic o, input logic po);
		if ($countones(r) > 1)
			return shop_mon_pkg::viol_multi_strobe;
		if ((r & pr) != 5'b0 || (o && po))
			return shop_mon_pkg::viol_held_strobe;
		return shop_mon_pkg::viol_none;
	endfunction

	function automatic shop_mon_pkg::viol_e order_model(input shop_mon_pkg::phase_e ph,
		input logic [4:0] r, input logic o);
		logic [4:0] allowed;
		case (ph)
			shop_mon_pkg::ph_idle:       allowed = S_ID | S_ACT;
			shop_mon_pkg::ph_user:       allowed = S_ACT;
			shop_mon_pkg::ph_item:       allowed = S_ITEM;
			shop_mon_pkg::ph_num:        allowed = S_NUM;
			shop_mon_pkg::ph_amount:     allowed = S_AMNT;
			shop_mon_pkg::ph_seller:     allowed = S_ID;
			shop_mon_pkg::ph_check_open: allowed = S_ID;
			default:                     allowed = 5'b0;
		endcase
		if ((r & ~allowed) != 5'b0)
			return shop_mon_pkg::viol_order;
		if (o && ph != shop_mon_pkg::ph_check_open && ph != shop_mon_pkg::ph_done)
			return shop_mon_pkg::viol_early_resp;
		return shop_mon_pkg::viol_none;
	endfunction

	function automatic shop_mon_pkg::phase_e next_phase(input shop_mon_pkg::phase_e ph,
		input logic [4:0] r, input shop_mon_pkg::action_e a, input logic o);
		shop_mon_pkg::phase_e branch;
		branch = shop_mon_pkg::ph_item;
		if (a == shop_mon_pkg::act_deposit)
			branch = shop_mon_pkg::ph_amount;
		else if (a == shop_mon_pkg::act_check)
			branch = shop_mon_pkg::ph_check_open;
		if (o)
			return shop_mon_pkg::ph_idle;
		// Action code decides the branch, even next to a user id
		if ((ph == shop_mon_pkg::ph_idle || ph == shop_mon_pkg::ph_user) && (r & S_ACT) != 0)
			return branch;
		if (ph == shop_mon_pkg::ph_idle && (r & S_ID) != 0)
			return shop_mon_pkg::ph_user;
		if (ph == shop_mon_pkg::ph_item && (r & S_ITEM) != 0)
			return shop_mon_pkg::ph_num;
		if (ph == shop_mon_pkg::ph_num && (r & S_NUM) != 0)
			return shop_mon_pkg::ph_seller;
		if (ph == shop_mon_pkg::ph_amount && (r & S_AMNT) != 0)
			return shop_mon_pkg::ph_done;
		if ((ph == shop_mon_pkg::ph_seller || ph == shop_mon_pkg::ph_check_open)
			&& (r & S_ID) != 0)
			return shop_mon_pkg::ph_done;
		return ph;
	endfunction

	function automatic shop_mon_pkg::viol_e pick_model(input logic [4:0] mask,
		input shop_mon_pkg::viol_e s, input shop_mon_pkg::viol_e q,
		input shop_mon_pkg::viol_e p);
		shop_mon_pkg::viol_e cand [3];
		cand[0] = s;
		cand[1] = q;
		cand[2] = p;
		for (int k = 0; k < 3; k++) begin
			if (cand[k] != shop_mon_pkg::viol_none && mask[int'(cand[k]) - 1])
				return cand[k];
		end
		return shop_mon_pkg::viol_none;
	endfunction

	assign cur_req  = {id_valid, act_valid, item_valid, num_valid, amnt_valid};
	assign c_strobe = strobe_model(cur_req, m_prev_req, out_valid, m_prev_out);
	assign c_order  = order_model(m_phase, cur_req, out_valid);
	assign c_resp   = (out_valid && ((complete && err_msg != '0) || (!complete && out_info != '0)))
		? shop_mon_pkg::viol_resp_field : shop_mon_pkg::viol_none;
	assign m_pick   = pick_model(m_mask, c_strobe, c_order, c_resp);

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			m_prev_req <= '0;
			m_prev_out <= 1'b0;
			m_phase    <= shop_mon_pkg::ph_idle;
			m_mask     <= '1;
			exp_valid  <= 1'b0;
			exp_code   <= shop_mon_pkg::viol_none;
			exp_count  <= '0;
			exp_first  <= shop_mon_pkg::viol_none;
		end else begin
			m_prev_req <= cur_req;
			m_prev_out <= out_valid;
			m_phase    <= next_phase(m_phase, cur_req, act, out_valid);
			if (cfg_we)
				m_mask <= cfg_mask;
			exp_valid <= (m_pick != shop_mon_pkg::viol_none);
			exp_code  <= m_pick;
			if (m_pick != shop_mon_pkg::viol_none)
				seen[m_pick] <= 1'b1;
			if (cfg_clear) begin
				exp_count <= (m_pick != shop_mon_pkg::viol_none) ? 1 : 0;
				exp_first <= m_pick;
			end else begin
				if (m_pick != shop_mon_pkg::viol_none && exp_count != '1)
					exp_count <= exp_count + 1'b1;
				if (exp_first == shop_mon_pkg::viol_none)
					exp_first <= m_pick;
			end
		end
	end

	// Report outputs follow the model one cycle after each sample
	a_report : assert property (@(posedge clk) disable iff (!rst_n)
		viol_valid == exp_valid && viol_code == exp_code
		&& viol_count == exp_count && first_code == exp_first)
	else begin
		errors++;
		$display("MISMATCH at %0t: got valid %b code %0d count %0d first %0d", $time,
			$sampled(viol_valid), $sampled(viol_code), $sampled(viol_count),
			$sampled(first_code));
		$display("  expected valid %b code %0d count %0d first %0d", $sampled(exp_valid),
			$sampled(exp_code), $sampled(exp_count), $sampled(exp_first));
	end

	// ##################################################
	// Stimulus tasks
	// ##################################################
	task automatic drive(input logic [4:0] r, input shop_mon_pkg::action_e a, input logic o,
		input logic c, input logic [shop_mon_pkg::ERR_W-1:0] e,
		input logic [shop_mon_pkg::INFO_W-1:0] i);
		@(posedge clk);
		{id_valid, act_valid, item_valid, num_valid, amnt_valid} <= r;
		act       <= a;
		out_valid <= o;
		complete  <= c;
		err_msg   <= e;
		out_info  <= i;
		cfg_we    <= 1'b0;
		cfg_clear <= 1'b0;
	endtask

	task automatic strobe(input logic [4:0] r, input shop_mon_pkg::action_e a);
		drive(r, a, 1'b0, 1'b0, '0, '0);
	endtask

	task automatic idle_cycle();
		drive(5'b0, act, 1'b0, 1'b0, '0, '0);
	endtask

	// Legal response with random payload
	task automatic respond_ok();
		logic [31:0] rnd;
		rnd = $random(seed);
		if (rnd[0])
			drive(5'b0, act, 1'b1, 1'b1, '0, $random(seed));
		else
			drive(5'b0, act, 1'b1, 1'b0, rnd[7:4], '0);
	endtask

	task automatic legal_sequence(input shop_mon_pkg::action_e a, input logic user);
		logic seller;
		seller = $random(seed);
		if (user)
			strobe(S_ID, a);
		strobe(S_ACT, a);
		case (a)
			shop_mon_pkg::act_deposit: strobe(S_AMNT, a);
			shop_mon_pkg::act_check: begin
				if (seller)
					strobe(S_ID, a);
			end
			default: begin
				strobe(S_ITEM, a);
				strobe(S_NUM, a);
				strobe(S_ID, a);
			end
		endcase
		respond_ok();
		idle_cycle();
	endtask

	task automatic set_mask(input logic [4:0] m);
		idle_cycle();
		cfg_we   <= 1'b1;
		cfg_mask <= m;
	endtask

	// Ends the stimulus, then waits for the reported event
	task automatic expect_event(input shop_mon_pkg::viol_e code);
		int waited;
		waited = 0;
		idle_cycle();
		@(negedge clk);
		while (!viol_valid && waited < 4) begin
			@(negedge clk);
			waited++;
		end
		if (!viol_valid) begin
			errors++;
			$display("No violation reported within 4 cycles, code %0d was due", code);
		end else begin
			assert (viol_code == code)
			else begin
				errors++;
				$display("MISMATCH at %0t: code %0d, expected %0d", $time, viol_code, code);
			end
		end
	endtask

	task automatic check_counts(input int cnt, input shop_mon_pkg::viol_e first);
		idle_cycle();
		@(negedge clk);
		assert (viol_count == cnt && first_code == first)
		else begin
			errors++;
			$display("MISMATCH at %0t: count %0d first %0d, expected %0d and %0d", $time,
				viol_count, first_code, cnt, first);
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("%-10s %s", name, (errors == err_mark) ? "passed" : "had errors");
		err_mark = errors;
	endtask

	// ##################################################
	// Test sequence
	// ##################################################
	initial begin
		logic [31:0] rnd;
		rst_n      = 1'b0;
		{id_valid, act_valid, item_valid, num_valid, amnt_valid} = '0;
		act        = shop_mon_pkg::act_buy;
		out_valid  = 1'b0;
		complete   = 1'b0;
		err_msg    = '0;
		out_info   = '0;
		cfg_we     = 1'b0;
		cfg_mask   = '1;
		cfg_clear  = 1'b0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		idle_cycle();

		for (int a = 0; a < 4; a++) begin
			legal_sequence(shop_mon_pkg::action_e'(a), 1'b0);
			legal_sequence(shop_mon_pkg::action_e'(a), 1'b1);
		end
		check_counts(0, shop_mon_pkg::viol_none);
		end_test("legal");

		strobe(S_ITEM | S_NUM, shop_mon_pkg::act_buy);
		expect_event(shop_mon_pkg::viol_multi_strobe);
		strobe(S_ACT, shop_mon_pkg::act_deposit);
		strobe(S_AMNT, shop_mon_pkg::act_deposit);
		strobe(S_AMNT, shop_mon_pkg::act_deposit);
		expect_event(shop_mon_pkg::viol_held_strobe);
		drive(5'b0, shop_mon_pkg::act_deposit, 1'b1, 1'b1, '0, '0);
		drive(5'b0, shop_mon_pkg::act_deposit, 1'b1, 1'b1, '0, '0);
		expect_event(shop_mon_pkg::viol_held_strobe);
		end_test("strobes");

		// Item before act, amnt during buy, response in ph_num, strobe after done
		strobe(S_ID, shop_mon_pkg::act_deposit);
		strobe(S_ITEM, shop_mon_pkg::act_deposit);
		expect_event(shop_mon_pkg::viol_order);
		strobe(S_ACT, shop_mon_pkg::act_deposit);
		strobe(S_AMNT, shop_mon_pkg::act_deposit);
		respond_ok();
		strobe(S_ACT, shop_mon_pkg::act_buy);
		strobe(S_ITEM, shop_mon_pkg::act_buy);
		strobe(S_AMNT, shop_mon_pkg::act_buy);
		expect_event(shop_mon_pkg::viol_order);
		drive(5'b0, shop_mon_pkg::act_buy, 1'b1, 1'b1, '0, '0);
		expect_event(shop_mon_pkg::viol_early_resp);
		strobe(S_ACT, shop_mon_pkg::act_deposit);
		strobe(S_AMNT, shop_mon_pkg::act_deposit);
		strobe(S_NUM, shop_mon_pkg::act_deposit);
		expect_event(shop_mon_pkg::viol_order);
		respond_ok();
		end_test("order");

		strobe(S_ACT, shop_mon_pkg::act_check);
		drive(5'b0, shop_mon_pkg::act_check, 1'b1, 1'b1, 4'h3, '0);
		expect_event(shop_mon_pkg::viol_resp_field);
		strobe(S_ACT, shop_mon_pkg::act_check);
		drive(5'b0, shop_mon_pkg::act_check, 1'b1, 1'b0, '0, 32'h55);
		expect_event(shop_mon_pkg::viol_resp_field);
		end_test("response");

		// One cycle breaking every checker, then masking down the priority list
		drive(S_ITEM | S_NUM, shop_mon_pkg::act_buy, 1'b1, 1'b1, 4'h9, '0);
		expect_event(shop_mon_pkg::viol_multi_strobe);
		set_mask(5'b11100);
		drive(S_ITEM | S_NUM, shop_mon_pkg::act_buy, 1'b1, 1'b1, 4'h9, '0);
		expect_event(shop_mon_pkg::viol_order);
		set_mask(5'b10000);
		drive(S_ITEM | S_NUM, shop_mon_pkg::act_buy, 1'b1, 1'b1, 4'h9, '0);
		expect_event(shop_mon_pkg::viol_resp_field);
		set_mask(5'b00000);
		drive(S_ITEM | S_NUM, shop_mon_pkg::act_buy, 1'b1, 1'b1, 4'h9, '0);
		idle_cycle();
		set_mask(5'b11111);
		end_test("priority");

		idle_cycle();
		cfg_clear <= 1'b1;
		check_counts(0, shop_mon_pkg::viol_none);
		strobe(S_ITEM, shop_mon_pkg::act_buy);
		expect_event(shop_mon_pkg::viol_order);
		strobe(S_ITEM | S_AMNT, shop_mon_pkg::act_buy);
		expect_event(shop_mon_pkg::viol_multi_strobe);
		check_counts(2, shop_mon_pkg::viol_order);
		// Clear together with a violation
		strobe(S_ITEM, shop_mon_pkg::act_buy);
		cfg_clear <= 1'b1;
		expect_event(shop_mon_pkg::viol_order);
		check_counts(1, shop_mon_pkg::viol_order);
		end_test("counts");

		// Sparse random cycles, then random legal sequences
		for (int n = 0; n < 60; n++) begin
			rnd = $random(seed);
			drive(rnd[4:0] & rnd[9:5] & rnd[14:10], shop_mon_pkg::action_e'(rnd[27:26]),
				rnd[15] & rnd[16], rnd[17], rnd[20] ? rnd[24:21] : 4'h0,
				rnd[25] ? 32'(rnd[31:28]) : 32'h0);
		end
		drive(5'b0, act, 1'b1, 1'b1, '0, '0);
		idle_cycle();
		for (int n = 0; n < 12; n++) begin
			rnd = $random(seed);
			legal_sequence(shop_mon_pkg::action_e'(rnd[1:0]), rnd[2]);
		end
		end_test("random");

		assert (seen[5:1] == 5'b11111)
		else begin
			errors++;
			$display("Not every violation code was reached, seen %b", seen[5:1]);
		end

		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

	// Watchdog against a stuck run
	initial begin
		repeat (20000) @(posedge clk);
		$display("Simulation stopped by the watchdog after 20000 cycles");
		$display("Test failed");
		$finish;
	end

endmodule

// ==== violation_report.sv ====
// Violation reporting stage
// Rule mask register, fixed priority pick, registered event,
// saturating count and first-code capture

`timescale 1ns/1ns

module violation_report (
	input  logic                              clk,
	input  logic                              rst_n,
	input  shop_mon_pkg::viol_e               viol_strobe,
	input  shop_mon_pkg::viol_e               viol_order,
	input  shop_mon_pkg::viol_e               viol_resp,
	input  logic                              cfg_we,
	input  logic [shop_mon_pkg::RULE_N-1:0]   cfg_mask,
	input  logic                              cfg_clear,
	output logic                              viol_valid,
	output shop_mon_pkg::viol_e               viol_code,
	output logic [shop_mon_pkg::CNT_W-1:0]    viol_count,
	output shop_mon_pkg::viol_e               first_code
);

	logic [shop_mon_pkg::RULE_N-1:0] mask;
	shop_mon_pkg::viol_e             pick;
	logic                            pick_valid;

	// Mask bit k enables code k+1 and viol_none never passes
	function automatic logic rule_on(input shop_mon_pkg::viol_e code,
		input logic [shop_mon_pkg::RULE_N-1:0] m);
		logic on;
		on = 1'b0;
		for (int k = 0; k < shop_mon_pkg::RULE_N; k++) begin
			if (int'(code) == k + 1)
				on = m[k];
		end
		return on;
	endfunction

	// Strobe rules win, then order, then response fields
	always_comb begin
		pick = shop_mon_pkg::viol_none;
		if (rule_on(viol_strobe, mask))
			pick = viol_strobe;
		else if (rule_on(viol_order, mask))
			pick = viol_order;
		else if (rule_on(viol_resp, mask))
			pick = viol_resp;
	end

	assign pick_valid = (pick != shop_mon_pkg::viol_none);

	// ##################################################
	// Report registers
	// ##################################################
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mask       <= '1;
			viol_valid <= 1'b0;
			viol_code  <= shop_mon_pkg::viol_none;
			viol_count <= '0;
			first_code <= shop_mon_pkg::viol_none;
		end else begin
			if (cfg_we)
				mask <= cfg_mask;
			viol_valid <= pick_valid;
			viol_code  <= pick;
			if (cfg_clear) begin
				// A same-cycle report is the first one after the clear
				viol_count <= pick_valid ? shop_mon_pkg::CNT_W'(1) : '0;
				first_code <= pick;
			end else begin
				if (pick_valid && (viol_count != '1))
					viol_count <= viol_count + 1'b1;
				if (first_code == shop_mon_pkg::viol_none)
					first_code <= pick;
			end
		end
	end

	a_valid_code : assert property (@(posedge clk) disable iff (!rst_n)
		viol_valid |-> viol_code != shop_mon_pkg::viol_none);

endmodule
